/* logic/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// local data memory geometry
`define DMEM_WORDS 256
`define DMEM_IDX_W 8                  // log2 of DMEM_WORDS

// device space starts here
`define DEV_BASE 64'h0000_0000_1000_0000

// device bus flow control
`define DEV_CREDITS 2
`define DEV_CREDIT_W 2                // wide enough to hold DEV_CREDITS

// status register fields
`define STATUS_IE 0
`define STATUS_EXL 1
`define STATUS_IM_LO 8
`define STATUS_IM_W 8

// cause register fields
`define CAUSE_EXC_LO 2                // 5-bit exception code
`define CAUSE_IP_LO 8                 // pending interrupts, 8 bits

`endif

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // memory access carried down from execute
    typedef enum logic [2:0] {
        mem_none               = 3'd0,
        mem_load_word          = 3'd1,
        mem_load_byte          = 3'd2,
        mem_load_byte_unsigned = 3'd3,
        mem_store_word         = 3'd4,
        mem_store_byte         = 3'd5
    } mem_op_e;

    // coprocessor-0 instruction class
    typedef enum logic [1:0] {
        cp0_none = 2'd0,
        cp0_mtc0 = 2'd1,
        cp0_mfc0 = 2'd2,
        cp0_eret = 2'd3
    } cp0_op_e;

endpackage

`default_nettype wire

/* logic/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // register numbers as seen by mtc0 / mfc0
    typedef enum logic [4:0] {
        reg_status = 5'd12,
        reg_cause  = 5'd13,
        reg_epc    = 5'd14
    } cp0_reg_e;

    // codes written to the cause register
    typedef enum logic [4:0] {
        exc_interrupt     = 5'd0,
        exc_reserved_inst = 5'd10,
        exc_overflow      = 5'd12
    } exc_code_e;

endpackage

`default_nettype wire

/* logic/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module data_mem (
    input  logic        clock,
    input  logic        reset,
    input  logic [63:0] addr,
    input  logic [63:0] wdata,
    input  logic        word_we,
    input  logic        byte_we,
    input  logic [63:0] inst_addr,
    output logic [63:0] rdata,
    output logic [31:0] inst
);

    logic [63:0] mem [0:`DMEM_WORDS-1];

    logic [`DMEM_IDX_W-1:0] data_idx;
    logic [`DMEM_IDX_W-1:0] inst_idx;
    logic [5:0]             lane_lsb;  // bit offset of the addressed byte
    logic [63:0]            inst_word;

    assign data_idx = addr[3 +: `DMEM_IDX_W];
    assign inst_idx = inst_addr[3 +: `DMEM_IDX_W];
    assign lane_lsb = {addr[2:0], 3'b000};

    // writes are held off while the core is in reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            if (word_we) begin
                mem[data_idx] <= wdata;
            end else if (byte_we) begin
                mem[data_idx][lane_lsb +: 8] <= wdata[7:0];  // one lane only
            end
        end
    end

    // asynchronous read, a load right after a store sees new data
    assign rdata = mem[data_idx];

    // fetch port, two instructions per 64-bit word
    assign inst_word = mem[inst_idx];
    assign inst      = inst_addr[2] ? inst_word[63:32] : inst_word[31:0];

endmodule

`default_nettype wire

/* logic/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  pipe_pkg::mem_op_e mem_op,
    input  pipe_pkg::cp0_op_e cp0_op,
    input  logic [2:0]        addr_low,
    input  logic [63:0]       alu_value,
    input  logic [63:0]       mem_rdata,
    input  logic              dev_hit,
    input  logic [63:0]       dev_rdata,
    input  logic [63:0]       cp0_rdata,
    output logic [63:0]       w_data
);

    logic [7:0]  lane;
    logic [63:0] byte_ext;
    logic [63:0] mem_value;
    logic        is_byte_load;
    logic        is_load;

    assign lane = mem_rdata[{addr_low, 3'b000} +: 8];

    assign is_byte_load = (mem_op == pipe_pkg::mem_load_byte)
                       || (mem_op == pipe_pkg::mem_load_byte_unsigned);
    assign is_load      = is_byte_load || (mem_op == pipe_pkg::mem_load_word);

    // lbu zero fills, lb copies bit 7
    assign byte_ext  = (mem_op == pipe_pkg::mem_load_byte) ? {{56{lane[7]}}, lane}
                                                           : {56'b0, lane};
    assign mem_value = is_byte_load ? byte_ext : mem_rdata;

    always_comb begin
        if (cp0_op == pipe_pkg::cp0_mfc0) begin
            w_data = cp0_rdata;
        end else if (is_load && dev_hit) begin
            w_data = dev_rdata;  // held device response
        end else if (is_load) begin
            w_data = mem_value;
        end else begin
            w_data = alu_value;
        end
    end

endmodule

`default_nettype wire

/* logic/cp0.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module cp0 (
    input  logic              clock,
    input  logic              reset,
    input  logic              accept,
    input  pipe_pkg::cp0_op_e cp0_op,
    input  logic [4:0]        regnum,
    input  logic [63:0]       wdata,
    input  logic [63:0]       next_pc,
    input  logic [7:0]        interrupt_sources,
    input  logic              overflow,
    input  logic              reserved_inst,
    output logic [63:0]       rdata,
    output logic [63:0]       epc,
    output logic              taken_handler
);

    logic [63:0] status_q;
    logic [63:0] cause_q;
    logic [63:0] epc_q;

    logic [7:0]             pending;
    logic                   int_taken;
    cp0_pkg::exc_code_e     exc_code;

    assign pending   = interrupt_sources & status_q[`STATUS_IM_LO +: `STATUS_IM_W];
    assign int_taken = (|pending) && status_q[`STATUS_IE] && !status_q[`STATUS_EXL];

    assign taken_handler = overflow || reserved_inst || int_taken;

    // exceptions beat interrupts, overflow beats reserved_inst
    always_comb begin
        if (overflow) begin
            exc_code = cp0_pkg::exc_overflow;
        end else if (reserved_inst) begin
            exc_code = cp0_pkg::exc_reserved_inst;
        end else begin
            exc_code = cp0_pkg::exc_interrupt;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else if (accept) begin
            if (taken_handler) begin
                epc_q                            <= next_pc;
                status_q[`STATUS_EXL]            <= 1'b1;
                cause_q[`CAUSE_EXC_LO +: 5]      <= exc_code;
            end else if (cp0_op == pipe_pkg::cp0_mtc0) begin
                case (regnum)
                    cp0_pkg::reg_status: status_q <= wdata;
                    cp0_pkg::reg_cause:  cause_q  <= wdata;
                    cp0_pkg::reg_epc:    epc_q    <= wdata;
                    default: ;                     // other numbers not implemented
                endcase
            end else if (cp0_op == pipe_pkg::cp0_eret) begin
                status_q[`STATUS_EXL] <= 1'b0;  // back to normal level
            end
        end
    end

    // mfc0 read, cause shows raw pending lines
    always_comb begin
        case (regnum)
            cp0_pkg::reg_status: rdata = status_q;
            cp0_pkg::reg_cause:  rdata = {cause_q[63:`CAUSE_IP_LO+8], interrupt_sources,
                                          cause_q[`CAUSE_IP_LO-1:0]};
            cp0_pkg::reg_epc:    rdata = epc_q;
            default:             rdata = '0;
        endcase
    end

    assign epc = epc_q;

endmodule

`default_nettype wire

/* logic/dev_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module dev_port (
    input  logic        clock,
    input  logic        reset,
    input  logic        dev_hit,
    input  logic        is_write,
    input  logic [63:0] addr,
    input  logic [63:0] wdata,
    input  logic        dev_credit,
    input  logic        dev_rsp_valid,
    input  logic [63:0] dev_rsp_data,
    output logic        stall,
    output logic [63:0] rsp_data,
    output logic        dev_req_valid,
    output logic        dev_req_write,
    output logic [63:0] dev_req_addr,
    output logic [63:0] dev_req_wdata
);

    logic [`DEV_CREDIT_W-1:0] credit_q;
    logic                     issued_q;  // request already sent
    logic                     held_q;    // load response captured
    logic                     complete;
    logic                     issue;
    logic                     done;

    assign issue    = dev_hit && !issued_q && (credit_q != '0);
    assign complete = is_write ? issued_q : held_q;
    assign stall    = dev_hit && !complete;
    assign done     = dev_hit && !stall;  // stage takes the instruction

    assign dev_req_valid = issue;
    assign dev_req_write = is_write;
    assign dev_req_addr  = addr;
    assign dev_req_wdata = wdata;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            credit_q <= `DEV_CREDIT_W'(`DEV_CREDITS);
        end else if (issue && !dev_credit) begin
            credit_q <= credit_q - 1'b1;
        end else if (dev_credit && !issue) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            issued_q <= 1'b0;
            held_q   <= 1'b0;
        end else if (done) begin
            issued_q <= 1'b0;
            held_q   <= 1'b0;
        end else begin
            if (issue) begin
                issued_q <= 1'b1;
            end
            if (dev_rsp_valid && issued_q && !is_write) begin
                held_q <= 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge clock) begin
        if (dev_rsp_valid && issued_q && !held_q) begin
            rsp_data <= dev_rsp_data;
        end
    end

endmodule

`default_nettype wire

/* logic/core_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_mem (
    input  logic              clock,
    input  logic              reset,
    input  logic              ex_valid,
    input  logic [63:0]       ex_result,
    input  logic [63:0]       ex_b_data,
    input  logic [4:0]        ex_w_regnum,
    input  logic              ex_write_enable,
    input  pipe_pkg::mem_op_e ex_mem_op,
    input  pipe_pkg::cp0_op_e ex_cp0_op,
    input  logic              ex_overflow,
    input  logic              ex_reserved_inst,
    input  logic [63:0]       next_pc,
    input  logic [7:0]        interrupt_sources,
    input  logic [63:0]       inst_addr,
    input  logic              dev_credit,
    input  logic              dev_rsp_valid,
    input  logic [63:0]       dev_rsp_data,
    output logic [31:0]       inst,
    output logic              stall,
    output logic              mem_valid,
    output logic [63:0]       mem_w_data,
    output logic [4:0]        mem_w_regnum,
    output logic              mem_write_enable,
    output logic              mem_mem_read,
    output logic [63:0]       mem_epc,
    output logic              mem_taken_handler,
    output logic              dev_req_valid,
    output logic              dev_req_write,
    output logic [63:0]       dev_req_addr,
    output logic [63:0]       dev_req_wdata
);

    logic        is_load;
    logic        is_store;
    logic        dev_space;
    logic        dev_hit;
    logic        accept;
    logic        local_store;
    logic        taken_handler;
    logic [63:0] mem_rdata;
    logic [63:0] dev_rdata;
    logic [63:0] cp0_rdata;
    logic [63:0] epc;
    logic [63:0] w_data;

    assign is_load  = (ex_mem_op == pipe_pkg::mem_load_word)
                   || (ex_mem_op == pipe_pkg::mem_load_byte)
                   || (ex_mem_op == pipe_pkg::mem_load_byte_unsigned);
    assign is_store = (ex_mem_op == pipe_pkg::mem_store_word)
                   || (ex_mem_op == pipe_pkg::mem_store_byte);

    assign dev_space = (ex_result >= `DEV_BASE);
    // faulting instructions never reach the device
    assign dev_hit   = ex_valid && (is_load || is_store) && dev_space
                    && !ex_overflow && !ex_reserved_inst;

    assign accept      = ex_valid && !stall;
    assign local_store = accept && !dev_space && !taken_handler;

    data_mem u_data_mem (
        .clock     (clock),
        .reset     (reset),
        .addr      (ex_result),
        .wdata     (ex_b_data),
        .word_we   (local_store && (ex_mem_op == pipe_pkg::mem_store_word)),
        .byte_we   (local_store && (ex_mem_op == pipe_pkg::mem_store_byte)),
        .inst_addr (inst_addr),
        .rdata     (mem_rdata),
        .inst      (inst)
    );

    dev_port u_dev_port (
        .clock         (clock),
        .reset         (reset),
        .dev_hit       (dev_hit),
        .is_write      (is_store),
        .addr          (ex_result),
        .wdata         (ex_b_data),
        .dev_credit    (dev_credit),
        .dev_rsp_valid (dev_rsp_valid),
        .dev_rsp_data  (dev_rsp_data),
        .stall         (stall),
        .rsp_data      (dev_rdata),
        .dev_req_valid (dev_req_valid),
        .dev_req_write (dev_req_write),
        .dev_req_addr  (dev_req_addr),
        .dev_req_wdata (dev_req_wdata)
    );

    cp0 u_cp0 (
        .clock             (clock),
        .reset             (reset),
        .accept            (accept),
        .cp0_op            (ex_cp0_op),
        .regnum            (ex_w_regnum),
        .wdata             (ex_b_data),
        .next_pc           (next_pc),
        .interrupt_sources (interrupt_sources),
        .overflow          (ex_overflow),
        .reserved_inst     (ex_reserved_inst),
        .rdata             (cp0_rdata),
        .epc               (epc),
        .taken_handler     (taken_handler)
    );

    load_align u_load_align (
        .mem_op    (ex_mem_op),
        .cp0_op    (ex_cp0_op),
        .addr_low  (ex_result[2:0]),
        .alu_value (ex_result),
        .mem_rdata (mem_rdata),
        .dev_hit   (dev_hit),
        .dev_rdata (dev_rdata),
        .cp0_rdata (cp0_rdata),
        .w_data    (w_data)
    );

    // control half of the output register, bubbles on every non-accept cycle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mem_valid         <= 1'b0;
            mem_write_enable  <= 1'b0;
            mem_taken_handler <= 1'b0;
            mem_mem_read      <= 1'b0;
        end else begin
            mem_valid         <= accept;
            mem_write_enable  <= accept && ex_write_enable && !taken_handler;
            mem_taken_handler <= accept && taken_handler;
            mem_mem_read      <= accept && is_load;
        end
    end

    // write-back payload
    always_ff @(posedge clock) begin
        if (accept) begin
            mem_w_data   <= w_data;
            mem_w_regnum <= ex_w_regnum;
            mem_epc      <= taken_handler ? next_pc : epc;  // new epc on entry
        end
    end

endmodule

`default_nettype wire

/* testbench/core_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_mem_tb;

    localparam int instr_count = 47;                              // instructions in the stimulus
    localparam int cycle_limit = 10 * (4 + 8 + instr_count * 8);  // 8 cycles worst per instruction

    logic              clock;
    logic              reset;
    logic              ex_valid;
    logic [63:0]       ex_result;
    logic [63:0]       ex_b_data;
    logic [4:0]        ex_w_regnum;
    logic              ex_write_enable;
    pipe_pkg::mem_op_e ex_mem_op;
    pipe_pkg::cp0_op_e ex_cp0_op;
    logic              ex_overflow;
    logic              ex_reserved_inst;
    logic [63:0]       next_pc;
    logic [7:0]        interrupt_sources;
    logic [63:0]       inst_addr;
    logic              dev_credit;
    logic              dev_rsp_valid;
    logic [63:0]       dev_rsp_data;
    logic [31:0]       inst;
    logic              stall;
    logic              mem_valid;
    logic [63:0]       mem_w_data;
    logic [4:0]        mem_w_regnum;
    logic              mem_write_enable;
    logic              mem_mem_read;
    logic [63:0]       mem_epc;
    logic              mem_taken_handler;
    logic              dev_req_valid;
    logic              dev_req_write;
    logic [63:0]       dev_req_addr;
    logic [63:0]       dev_req_wdata;

    logic [63:0] ref_mem [0:`DMEM_WORDS-1];  // mirror of local memory
    logic [63:0] exp_status;
    logic [4:0]  exp_code;
    logic [63:0] exp_epc;
    logic [63:0] exp_w_data;
    logic [63:0] chk_w_data;
    logic [63:0] exp_epc_out;
    logic [63:0] chk_epc;
    logic [4:0]  chk_regnum;
    logic        exp_we;
    logic        chk_we;
    logic        exp_taken;
    logic        chk_taken;
    logic        exp_read;
    logic        chk_read;
    logic        exp_dev;
    logic        exp_req_write;
    logic        inst_chk;
    logic [63:0] exp_req_addr;
    logic [63:0] exp_req_wdata;
    logic [31:0] exp_inst;
    logic [63:0] pc;
    integer      seed;
    int          errors;
    int          instr_done;
    int          req_total;
    int          in_use;                     // credits held by the device
    int          cycle;
    int          cyc_dev;
    int          credit_due [$];
    int          rsp_due;
    logic        rsp_pending;
    logic [63:0] rsp_addr;

    core_mem uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [63:0] dev_data(input logic [63:0] addr);
        dev_data = {addr[31:0] ^ 32'hA5A5_5A5A, ~addr[31:0]};
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        errors++;
        $display("Error %s: got %h expected %h at %0t", name, got, want, $time);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // expected write-back fields follow the output register
    always @(posedge clock) begin
        if (!reset && ex_valid && !stall) begin
            chk_w_data <= exp_w_data;
            chk_epc    <= exp_epc_out;
            chk_regnum <= ex_w_regnum;
            chk_we     <= exp_we;
            chk_taken  <= exp_taken;
            chk_read   <= exp_read;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            req_total <= 0;
            in_use    <= 0;
        end else begin
            req_total <= req_total + int'(dev_req_valid);
            in_use    <= in_use + int'(dev_req_valid) - int'(dev_credit);
        end
    end

    assert property (@(posedge clock) disable iff (reset) mem_valid |-> mem_w_data == chk_w_data)
        else report_value("mem_w_data", $sampled(mem_w_data), $sampled(chk_w_data));
    assert property (@(posedge clock) disable iff (reset) mem_valid |-> mem_epc == chk_epc)
        else report_value("mem_epc", $sampled(mem_epc), $sampled(chk_epc));
    assert property (@(posedge clock) disable iff (reset) mem_valid |-> mem_w_regnum == chk_regnum)
        else report_value("mem_w_regnum", 64'($sampled(mem_w_regnum)), 64'($sampled(chk_regnum)));
    assert property (@(posedge clock) disable iff (reset) mem_valid |-> mem_write_enable == chk_we)
        else report_value("mem_write_enable", 64'($sampled(mem_write_enable)), 64'($sampled(chk_we)));
    assert property (@(posedge clock) disable iff (reset)
                     mem_valid |-> mem_taken_handler == chk_taken)
        else report_value("mem_taken_handler", 64'($sampled(mem_taken_handler)),
                          64'($sampled(chk_taken)));
    assert property (@(posedge clock) disable iff (reset) mem_valid |-> mem_mem_read == chk_read)
        else report_value("mem_mem_read", 64'($sampled(mem_mem_read)), 64'($sampled(chk_read)));
    assert property (@(posedge clock) disable iff (reset) inst_chk |-> inst == exp_inst)
        else report_value("inst", 64'($sampled(inst)), 64'($sampled(exp_inst)));
    assert property (@(posedge clock) disable iff (reset)
                     dev_req_valid |-> dev_req_addr == exp_req_addr)
        else report_value("dev_req_addr", $sampled(dev_req_addr), $sampled(exp_req_addr));
    assert property (@(posedge clock) disable iff (reset)
                     dev_req_valid |-> dev_req_write == exp_req_write)
        else report_value("dev_req_write", 64'($sampled(dev_req_write)),
                          64'($sampled(exp_req_write)));
    assert property (@(posedge clock) disable iff (reset)
                     (dev_req_valid && dev_req_write) |-> dev_req_wdata == exp_req_wdata)
        else report_value("dev_req_wdata", $sampled(dev_req_wdata), $sampled(exp_req_wdata));
    assert property (@(posedge clock) disable iff (reset) in_use <= `DEV_CREDITS)
        else report_fault("device holds more credits than it was given");
    assert property (@(posedge clock) disable iff (reset) in_use == `DEV_CREDITS |-> !dev_req_valid)
        else report_fault("request issued with no credit left");
    assert property (@(posedge clock) disable iff (reset) stall |-> exp_dev)
        else report_fault("stall raised for a local instruction");
    assert property (@(posedge clock) disable iff (reset) dev_req_valid |-> stall)
        else report_fault("instruction taken in the cycle its device request went out");

    // device model, credit and response 1 to 4 cycles after a request
    always @(negedge clock) begin
        int d;
        if (!reset && dev_req_valid) begin
            d = 1 + int'($unsigned($random(seed)) % 4);
            credit_due.push_back(cyc_dev + d);
            if (!dev_req_write) begin
                rsp_due     = cyc_dev + d;
                rsp_addr    = dev_req_addr;
                rsp_pending = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        logic found;
        cyc_dev = cyc_dev + 1;
        #1;
        dev_credit    = 1'b0;
        dev_rsp_valid = 1'b0;
        found         = 1'b0;
        for (int i = 0; i < credit_due.size(); i++) begin
            if (!found && credit_due[i] <= cyc_dev) begin
                credit_due.delete(i);
                dev_credit = 1'b1;  // one credit per pulse
                found      = 1'b1;
            end
        end
        if (rsp_pending && rsp_due <= cyc_dev) begin
            dev_rsp_valid = 1'b1;
            dev_rsp_data  = dev_data(rsp_addr);
            rsp_pending   = 1'b0;
        end
    end

    always @(posedge clock) begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout, stage did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d instructions, %0d errors", instr_done, errors + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic issue(input pipe_pkg::mem_op_e op, input pipe_pkg::cp0_op_e cop,
                         input logic [63:0] res, input logic [63:0] b, input logic [4:0] rn,
                         input logic we, input logic ovf, input logic ri);
        logic        taken;
        logic        is_load;
        logic        is_store;
        logic [63:0] word;
        logic [7:0]  lane;
        logic [7:0]  idx;
        int          start;
        is_load  = op inside {pipe_pkg::mem_load_word, pipe_pkg::mem_load_byte,
                              pipe_pkg::mem_load_byte_unsigned};
        is_store = op inside {pipe_pkg::mem_store_word, pipe_pkg::mem_store_byte};
        taken = ovf || ri || ((|(interrupt_sources & exp_status[`STATUS_IM_LO +: 8]))
                              && exp_status[`STATUS_IE] && !exp_status[`STATUS_EXL]);
        exp_dev = (is_load || is_store) && res >= `DEV_BASE && !ovf && !ri;
        idx  = res[10:3];
        word = ref_mem[idx];
        lane = word[{res[2:0], 3'b000} +: 8];
        if (cop == pipe_pkg::cp0_mfc0) begin
            case (rn)
                5'd12:   exp_w_data = exp_status;
                5'd13:   exp_w_data = {48'h0, interrupt_sources, 1'b0, exp_code, 2'b00};
                5'd14:   exp_w_data = exp_epc;
                default: exp_w_data = 64'h0;
            endcase
        end else if (exp_dev && is_load) begin
            exp_w_data = dev_data(res);
        end else if (op == pipe_pkg::mem_load_word) begin
            exp_w_data = word;
        end else if (op == pipe_pkg::mem_load_byte) begin
            exp_w_data = {{56{lane[7]}}, lane};
        end else if (op == pipe_pkg::mem_load_byte_unsigned) begin
            exp_w_data = {56'h0, lane};
        end else begin
            exp_w_data = res;
        end
        exp_epc_out   = taken ? pc : exp_epc;
        exp_we        = we && !taken;
        exp_taken     = taken;
        exp_read      = is_load;
        exp_req_addr  = res;
        exp_req_write = is_store;
        exp_req_wdata = b;
        start         = req_total;

        ex_valid         = 1'b1;
        ex_mem_op        = op;
        ex_cp0_op        = cop;
        ex_result        = res;
        ex_b_data        = b;
        ex_w_regnum      = rn;
        ex_write_enable  = we;
        ex_overflow      = ovf;
        ex_reserved_inst = ri;
        next_pc          = pc;
        @(negedge clock);
        while (stall) begin
            @(negedge clock);
        end
        @(posedge clock);
        #1;

        assert (mem_valid)
            else report_value("mem_valid", 64'(mem_valid), 64'h1);
        assert (req_total - start == int'(exp_dev))
            else report_fault($sformatf("wrong number of device requests: %0d",
                                        req_total - start));
        if (taken) begin
            exp_epc                = pc;
            exp_status[`STATUS_EXL] = 1'b1;
            exp_code               = ovf ? 5'd12 : (ri ? 5'd10 : 5'd0);
        end else if (cop == pipe_pkg::cp0_mtc0 && rn == 5'd12) begin
            exp_status = b;
        end else if (cop == pipe_pkg::cp0_mtc0 && rn == 5'd14) begin
            exp_epc = b;
        end else if (cop == pipe_pkg::cp0_eret) begin
            exp_status[`STATUS_EXL] = 1'b0;
        end
        if (!taken && res < `DEV_BASE && op == pipe_pkg::mem_store_word) begin
            ref_mem[idx] = b;
        end else if (!taken && res < `DEV_BASE && op == pipe_pkg::mem_store_byte) begin
            ref_mem[idx][{res[2:0], 3'b000} +: 8] = b[7:0];
        end
        pc = pc + 64'd4;
        instr_done++;
    endtask

    task automatic idle(input int n);
        ex_valid = 1'b0;
        exp_dev  = 1'b0;
        repeat (n) @(posedge clock);
        #1;
        assert (!mem_valid)
            else report_value("mem_valid", 64'(mem_valid), 64'h0);
    endtask

    task automatic alu_op(input logic [63:0] value);
        issue(pipe_pkg::mem_none, pipe_pkg::cp0_none, value, 64'h0, 5'd3, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic cp0_op(input pipe_pkg::cp0_op_e cop, input logic [4:0] rn,
                          input logic [63:0] b);
        issue(pipe_pkg::mem_none, cop, 64'h0, b, rn, cop == pipe_pkg::cp0_mfc0, 1'b0, 1'b0);
    endtask

    initial begin
        seed = 32'h1242;
        reset = 1'b1;
        ex_valid = 1'b0;
        ex_result = '0;
        ex_b_data = '0;
        ex_w_regnum = '0;
        ex_write_enable = 1'b0;
        ex_mem_op = pipe_pkg::mem_none;
        ex_cp0_op = pipe_pkg::cp0_none;
        ex_overflow = 1'b0;
        ex_reserved_inst = 1'b0;
        next_pc = '0;
        interrupt_sources = '0;
        inst_addr = '0;
        dev_credit = 1'b0;
        dev_rsp_valid = 1'b0;
        dev_rsp_data = '0;
        exp_status = '0;
        exp_code = '0;
        exp_epc = '0;
        exp_dev = 1'b0;
        inst_chk = 1'b0;
        pc = 64'h400;
        errors = 0;
        instr_done = 0;
        cycle = 0;
        cyc_dev = 0;
        rsp_pending = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        // local word and byte accesses
        issue(pipe_pkg::mem_store_word, pipe_pkg::cp0_none, 64'h40, 64'h1122_3344_5566_7788,
              5'd0, 1'b0, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_word, pipe_pkg::cp0_none, 64'h40, 64'h0, 5'd4, 1'b1, 1'b0, 1'b0);
        issue(pipe_pkg::mem_store_byte, pipe_pkg::cp0_none, 64'h43, 64'hAB, 5'd0, 1'b0, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_word, pipe_pkg::cp0_none, 64'h40, 64'h0, 5'd5, 1'b1, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_byte, pipe_pkg::cp0_none, 64'h43, 64'h0, 5'd6, 1'b1, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_byte_unsigned, pipe_pkg::cp0_none, 64'h43, 64'h0, 5'd7, 1'b1,
              1'b0, 1'b0);
        issue(pipe_pkg::mem_store_word, pipe_pkg::cp0_none, 64'h48, 64'h0123_4567_89AB_CD7F,
              5'd0, 1'b0, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_byte, pipe_pkg::cp0_none, 64'h48, 64'h0, 5'd8, 1'b1, 1'b0, 1'b0);
        issue(pipe_pkg::mem_load_byte_unsigned, pipe_pkg::cp0_none, 64'h4D, 64'h0, 5'd9, 1'b1,
              1'b0, 1'b0);
        alu_op(64'hDEAD_BEEF_0000_1234);
        issue(pipe_pkg::mem_store_word, pipe_pkg::cp0_none, 64'h10, 64'h0F0F_0000_F0F0_FFFF,
              5'd0, 1'b0, 1'b0, 1'b0);
        idle(1);

        // fetch port halves
        exp_inst  = ref_mem[8][63:32];
        inst_addr = 64'h44;
        inst_chk  = 1'b1;
        idle(2);
        exp_inst  = ref_mem[8][31:0];
        inst_addr = 64'h40;
        idle(2);
        inst_chk  = 1'b0;

        // device accesses, back to back
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 2) begin
                issue(pipe_pkg::mem_load_word, pipe_pkg::cp0_none, `DEV_BASE + 64'(i * 8),
                      64'h0, 5'd10, 1'b1, 1'b0, 1'b0);
            end else begin
                issue(pipe_pkg::mem_store_word, pipe_pkg::cp0_none, `DEV_BASE + 64'h10,
                      {32'($random(seed)), 32'($random(seed))}, 5'd0, 1'b0, 1'b0, 1'b0);
            end
        end
        issue(pipe_pkg::mem_load_word, pipe_pkg::cp0_none, 64'h10, 64'h0, 5'd11, 1'b1, 1'b0, 1'b0);

        // cp0 read and write
        cp0_op(pipe_pkg::cp0_mtc0, 5'd12, 64'h0000_0000_0000_FF00);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd12, 64'h0);
        interrupt_sources = 8'h04;
        cp0_op(pipe_pkg::cp0_mfc0, 5'd13, 64'h0);

        // overflow on a store, then reserved instruction
        issue(pipe_pkg::mem_store_word, pipe_pkg::cp0_none, 64'h40, 64'h5555_5555_5555_5555,
              5'd12, 1'b1, 1'b1, 1'b0);
        issue(pipe_pkg::mem_load_word, pipe_pkg::cp0_none, 64'h40, 64'h0, 5'd4, 1'b1, 1'b0, 1'b0);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd13, 64'h0);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd14, 64'h0);
        cp0_op(pipe_pkg::cp0_eret, 5'd0, 64'h0);
        issue(pipe_pkg::mem_none, pipe_pkg::cp0_none, 64'h77, 64'h0, 5'd2, 1'b1, 1'b0, 1'b1);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd13, 64'h0);
        cp0_op(pipe_pkg::cp0_eret, 5'd0, 64'h0);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd12, 64'h0);

        // interrupts masked, disabled, at exception level, then taken
        cp0_op(pipe_pkg::cp0_mtc0, 5'd12, 64'h0000_0000_0000_0400);
        alu_op(64'h1);
        cp0_op(pipe_pkg::cp0_mtc0, 5'd12, 64'h0000_0000_0000_0201);
        alu_op(64'h2);
        cp0_op(pipe_pkg::cp0_mtc0, 5'd12, 64'h0000_0000_0000_0403);
        alu_op(64'h3);
        interrupt_sources = 8'h00;
        cp0_op(pipe_pkg::cp0_mtc0, 5'd12, 64'h0000_0000_0000_0401);
        interrupt_sources = 8'h04;
        alu_op(64'h4);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd13, 64'h0);
        interrupt_sources = 8'h00;
        cp0_op(pipe_pkg::cp0_eret, 5'd0, 64'h0);
        cp0_op(pipe_pkg::cp0_mfc0, 5'd12, 64'h0);
        idle(3);

        $display("checks: %0d instructions, %0d errors", instr_done, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/pipe_pkg.sv
logic/cp0_pkg.sv
logic/data_mem.sv
logic/load_align.sv
logic/cp0.sv
logic/dev_port.sv
logic/core_mem.sv
testbench/core_mem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memory stage testbench with Verilator

verilator --binary --assert --top-module core_mem_tb -f list.f -o core_mem_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/core_mem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
fi
exit 1
